// File: logic/wb_pkg.sv
/*
  Shared definitions for the Wishbone system: bus widths, the address map
  of the two subordinates and the fixed words that appear on the bus.
  Imported by every RTL module and by the bound assertion module.
*/
package wb_pkg;

    localparam int WB_ADR_W = 32;
    localparam int WB_DAT_W = 32;
    localparam int WB_SEL_W = 4;

    // regions are selected by the address bits from here upward
    localparam int REGION_LSB = 16;

    localparam logic [WB_ADR_W-1:0] SRAM_BASE   = 32'h0000_0000;
    localparam logic [WB_ADR_W-1:0] PERIPH_BASE = 32'h0001_0000;

    // byte offsets of the peripheral registers inside their region
    localparam logic [REGION_LSB-1:0] PERIPH_OFS_COUNT   = 16'h0000;
    localparam logic [REGION_LSB-1:0] PERIPH_OFS_SCRATCH = 16'h0004;
    localparam logic [REGION_LSB-1:0] PERIPH_OFS_ID      = 16'h0008;

    localparam logic [WB_DAT_W-1:0] PERIPH_ID_WORD  = 32'h5742_0001;
    localparam logic [WB_DAT_W-1:0] UNMAPPED_WORD   = 32'hDEAD_BEEF;
    localparam logic [WB_DAT_W-1:0] MGR_POISON_WORD = 32'hBAD1_BAD1;

    typedef enum logic [1:0] {
        IDLE,
        WRITE,
        READ
    } mgr_state_t;

endpackage

// File: logic/wb_manager.sv
/*
  Single-transfer Wishbone manager. A write or read level from the user
  side starts one classic bus cycle; busy stays high until the cycle has
  been acknowledged. Read data is shown on rdata for the two cycles after
  busy falls and the poison word is shown at all other times.
  The user keeps adr, sel and wdata stable while busy is high.
*/
`timescale 1ns/1ps

module wb_manager (
    input  logic                          CLK,
    input  logic                          nRST,

    // user side
    input  logic                          write,
    input  logic                          read,
    input  logic [wb_pkg::WB_ADR_W-1:0]   adr,
    input  logic [wb_pkg::WB_SEL_W-1:0]   sel,
    input  logic [wb_pkg::WB_DAT_W-1:0]   wdata,
    output logic [wb_pkg::WB_DAT_W-1:0]   rdata,
    output logic                          busy,

    // bus side
    input  logic [wb_pkg::WB_DAT_W-1:0]   wb_rdata,
    input  logic                          wb_ack,
    output logic [wb_pkg::WB_ADR_W-1:0]   wb_adr,
    output logic [wb_pkg::WB_DAT_W-1:0]   wb_wdata,
    output logic [wb_pkg::WB_SEL_W-1:0]   wb_sel,
    output logic                          wb_we,
    output logic                          wb_stb,
    output logic                          wb_cyc
);
    import wb_pkg::*;

    mgr_state_t state;
    mgr_state_t next_state;

    logic [WB_ADR_W-1:0] next_adr;
    logic [WB_DAT_W-1:0] next_wdata;
    logic [WB_SEL_W-1:0] next_sel;
    logic                next_we;
    logic                next_stb;
    logic                next_cyc;
    logic                next_busy;
    logic [WB_DAT_W-1:0] next_rdata;

    // set by the first accepted request, rdata reads 0 before that
    logic armed;
    logic take;
    logic busy_prev;
    logic busy_fall;

    // exactly one of the two request levels
    assign take = (state == IDLE) && (write != read);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state    <= IDLE;
            armed    <= 1'b0;
            busy     <= 1'b0;
            rdata    <= '0;
            wb_adr   <= '0;
            wb_wdata <= '0;
            wb_sel   <= '0;
            wb_we    <= 1'b0;
            wb_stb   <= 1'b0;
            wb_cyc   <= 1'b0;
        end else begin
            state    <= next_state;
            armed    <= armed | take;
            busy     <= next_busy;
            rdata    <= next_rdata;
            wb_adr   <= next_adr;
            wb_wdata <= next_wdata;
            wb_sel   <= next_sel;
            wb_we    <= next_we;
            wb_stb   <= next_stb;
            wb_cyc   <= next_cyc;
        end
    end

    always_comb begin
        next_state = state;
        next_adr   = wb_adr;
        next_wdata = wb_wdata;
        next_sel   = wb_sel;
        next_we    = wb_we;
        next_stb   = wb_stb;
        next_cyc   = wb_cyc;
        next_busy  = busy;

        case (state)
            IDLE: begin
                if (write && !read) begin
                    next_busy  = 1'b1;
                    next_state = WRITE;
                end else if (read && !write) begin
                    next_busy  = 1'b1;
                    next_state = READ;
                end
            end
            WRITE, READ: begin
                // hold the user's request on the bus until ack
                next_adr   = adr;
                next_wdata = (state == WRITE) ? wdata : '0;
                next_sel   = sel;
                next_we    = (state == WRITE);
                next_stb   = 1'b1;
                next_cyc   = 1'b1;
                next_busy  = 1'b1;

                if (wb_ack) begin
                    next_state = IDLE;
                    next_adr   = '0;
                    next_wdata = '0;
                    next_sel   = '0;
                    next_we    = 1'b0;
                    next_stb   = 1'b0;
                    next_cyc   = 1'b0;
                    next_busy  = 1'b0;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy_prev <= 1'b0;
        end else begin
            busy_prev <= busy;
        end
    end

    // first idle cycle after a transfer
    assign busy_fall = busy_prev && !busy;

    always_comb begin
        next_rdata = armed ? MGR_POISON_WORD : '0;
        if ((state == READ) && wb_ack) begin
            next_rdata = wb_rdata;
        end else if (busy_fall) begin
            // keep the word for a second cycle
            next_rdata = rdata;
        end
    end

endmodule

// File: logic/wb_decoder.sv
/*
  Wishbone address decoder. Routes the manager's strobe to the SRAM or
  the peripheral block by the upper address bits and returns the chosen
  subordinate's read data and ack. Addresses outside both regions are
  answered here with UNMAPPED_WORD so the bus cannot hang.
*/
`timescale 1ns/1ps

module wb_decoder (
    input  logic                          CLK,
    input  logic                          nRST,

    // from and to the manager
    input  logic [wb_pkg::WB_ADR_W-1:0]   wb_adr,
    input  logic                          wb_stb,
    input  logic                          wb_cyc,
    output logic [wb_pkg::WB_DAT_W-1:0]   wb_rdata,
    output logic                          wb_ack,

    // subordinates
    output logic                          sram_stb,
    output logic                          periph_stb,
    input  logic [wb_pkg::WB_DAT_W-1:0]   sram_rdata,
    input  logic                          sram_ack,
    input  logic [wb_pkg::WB_DAT_W-1:0]   periph_rdata,
    input  logic                          periph_ack
);
    import wb_pkg::*;

    logic       hit_sram;
    logic       hit_periph;
    logic       unm_stb;
    // bit 0 marks the strobe as seen, bit 1 is the ack pulse
    logic [1:0] unm_q;

    assign hit_sram   = wb_adr[WB_ADR_W-1:REGION_LSB] == SRAM_BASE[WB_ADR_W-1:REGION_LSB];
    assign hit_periph = wb_adr[WB_ADR_W-1:REGION_LSB] == PERIPH_BASE[WB_ADR_W-1:REGION_LSB];

    assign sram_stb   = wb_stb && wb_cyc && hit_sram;
    assign periph_stb = wb_stb && wb_cyc && hit_periph;
    assign unm_stb    = wb_stb && wb_cyc && !hit_sram && !hit_periph;

    // responder for unmapped addresses, one ack per strobe
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            unm_q <= '0;
        end else begin
            unm_q[0] <= unm_stb && !unm_q[0] && !unm_q[1];
            unm_q[1] <= unm_q[0];
        end
    end

    always_comb begin
        if (hit_sram) begin
            wb_rdata = sram_rdata;
            wb_ack   = sram_ack;
        end else if (hit_periph) begin
            wb_rdata = periph_rdata;
            wb_ack   = periph_ack;
        end else begin
            wb_rdata = UNMAPPED_WORD;
            wb_ack   = unm_q[1];
        end
    end

endmodule

// File: logic/wb_sram.sv
/*
  Wishbone subordinate memory. Word addressed, byte-selectable writes.
  The access happens on the edge that first samples stb and the ack
  pulse follows one cycle later, together with the registered read word.
  A strobe held through the ack cycle is not served twice.
*/
`timescale 1ns/1ps

module wb_sram #(
    parameter int SRAM_WORDS = 256
) (
    input  logic                          CLK,
    input  logic                          nRST,
    input  logic                          stb,
    input  logic                          we,
    input  logic [wb_pkg::WB_ADR_W-1:0]   adr,
    input  logic [wb_pkg::WB_SEL_W-1:0]   sel,
    input  logic [wb_pkg::WB_DAT_W-1:0]   wdata,
    output logic [wb_pkg::WB_DAT_W-1:0]   rdata,
    output logic                          ack
);
    import wb_pkg::*;

    localparam int IDX_W = $clog2(SRAM_WORDS);
    localparam int OFS_W = $clog2(WB_SEL_W);

    logic [WB_DAT_W-1:0] mem [SRAM_WORDS];
    logic [IDX_W-1:0]    idx;
    logic                pend;
    logic                start;

    // word index wraps at the memory depth
    assign idx   = adr[IDX_W+OFS_W-1:OFS_W];
    assign start = stb && !pend && !ack;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pend <= 1'b0;
            ack  <= 1'b0;
        end else begin
            pend <= start;
            ack  <= pend;
        end
    end

    always_ff @(posedge CLK) begin
        if (start) begin
            if (we) begin
                for (int i = 0; i < WB_SEL_W; i++) begin
                    if (sel[i]) begin
                        mem[idx][i*8 +: 8] <= wdata[i*8 +: 8];
                    end
                end
            end else begin
                rdata <= mem[idx];
            end
        end
    end

endmodule

// File: logic/wb_periph.sv
/*
  Wishbone peripheral register block.
  Offset 0 is a free-running cycle counter (read only), offset 4 a scratch
  register with byte-select writes, offset 8 the identity word. Other
  offsets read 0. The ack is held back by PERIPH_WAIT cycles after the
  strobe is first sampled.
*/
`timescale 1ns/1ps

module wb_periph #(
    parameter int PERIPH_WAIT = 2
) (
    input  logic                          CLK,
    input  logic                          nRST,
    input  logic                          stb,
    input  logic                          we,
    input  logic [wb_pkg::WB_ADR_W-1:0]   adr,
    input  logic [wb_pkg::WB_SEL_W-1:0]   sel,
    input  logic [wb_pkg::WB_DAT_W-1:0]   wdata,
    output logic [wb_pkg::WB_DAT_W-1:0]   rdata,
    output logic                          ack
);
    import wb_pkg::*;

    localparam int CNT_W = (PERIPH_WAIT > 1) ? $clog2(PERIPH_WAIT) : 1;

    logic [WB_DAT_W-1:0]   count;
    logic [WB_DAT_W-1:0]   scratch;
    logic [WB_DAT_W-1:0]   rd_word;
    logic [CNT_W-1:0]      wait_cnt;
    logic [REGION_LSB-1:0] ofs;
    logic                  active;
    logic                  start;
    logic                  done;

    assign ofs   = adr[REGION_LSB-1:0];
    assign start = stb && !active && !ack;
    // access completes on the edge that raises ack
    assign done  = (PERIPH_WAIT == 0) ? start : (active && (wait_cnt == '0));

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            count    <= '0;
            scratch  <= '0;
            wait_cnt <= '0;
            active   <= 1'b0;
            ack      <= 1'b0;
        end else begin
            count <= count + 1'b1;
            ack   <= done;

            // wait-state down-counter
            if (start && (PERIPH_WAIT != 0)) begin
                active   <= 1'b1;
                wait_cnt <= CNT_W'(PERIPH_WAIT - 1);
            end else if (active) begin
                if (wait_cnt == '0) begin
                    active <= 1'b0;
                end else begin
                    wait_cnt <= wait_cnt - 1'b1;
                end
            end

            if (done && we && (ofs == PERIPH_OFS_SCRATCH)) begin
                for (int i = 0; i < WB_SEL_W; i++) begin
                    if (sel[i]) begin
                        scratch[i*8 +: 8] <= wdata[i*8 +: 8];
                    end
                end
            end
        end
    end

    always_comb begin
        case (ofs)
            PERIPH_OFS_COUNT:   rd_word = count;
            PERIPH_OFS_SCRATCH: rd_word = scratch;
            PERIPH_OFS_ID:      rd_word = PERIPH_ID_WORD;
            default:            rd_word = '0;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (done && !we) begin
            rdata <= rd_word;
        end
    end

endmodule

// File: logic/wb_soc.sv
/*
  Top level of the Wishbone system. The user request port drives the
  manager, whose cycle goes through the decoder to the SRAM or to the
  peripheral block. Memory depth and peripheral wait states are set here.
*/
`timescale 1ns/1ps

module wb_soc #(
    parameter int SRAM_WORDS  = 256,
    parameter int PERIPH_WAIT = 2
) (
    input  logic                          CLK,
    input  logic                          nRST,
    input  logic                          write,
    input  logic                          read,
    input  logic [wb_pkg::WB_ADR_W-1:0]   adr,
    input  logic [wb_pkg::WB_SEL_W-1:0]   sel,
    input  logic [wb_pkg::WB_DAT_W-1:0]   wdata,
    output logic [wb_pkg::WB_DAT_W-1:0]   rdata,
    output logic                          busy
);
    import wb_pkg::*;

    // shared downstream bus
    logic [WB_ADR_W-1:0] wb_adr;
    logic [WB_DAT_W-1:0] wb_wdata;
    logic [WB_SEL_W-1:0] wb_sel;
    logic                wb_we;
    logic                wb_stb;
    logic                wb_cyc;

    // return path to the manager
    logic [WB_DAT_W-1:0] wb_rdata;
    logic                wb_ack;

    logic                sram_stb;
    logic [WB_DAT_W-1:0] sram_rdata;
    logic                sram_ack;
    logic                periph_stb;
    logic [WB_DAT_W-1:0] periph_rdata;
    logic                periph_ack;

    wb_manager u_manager (
        .CLK      (CLK),
        .nRST     (nRST),
        .write    (write),
        .read     (read),
        .adr      (adr),
        .sel      (sel),
        .wdata    (wdata),
        .rdata    (rdata),
        .busy     (busy),
        .wb_rdata (wb_rdata),
        .wb_ack   (wb_ack),
        .wb_adr   (wb_adr),
        .wb_wdata (wb_wdata),
        .wb_sel   (wb_sel),
        .wb_we    (wb_we),
        .wb_stb   (wb_stb),
        .wb_cyc   (wb_cyc)
    );

    wb_decoder u_decoder (
        .CLK          (CLK),
        .nRST         (nRST),
        .wb_adr       (wb_adr),
        .wb_stb       (wb_stb),
        .wb_cyc       (wb_cyc),
        .wb_rdata     (wb_rdata),
        .wb_ack       (wb_ack),
        .sram_stb     (sram_stb),
        .periph_stb   (periph_stb),
        .sram_rdata   (sram_rdata),
        .sram_ack     (sram_ack),
        .periph_rdata (periph_rdata),
        .periph_ack   (periph_ack)
    );

    wb_sram #(
        .SRAM_WORDS (SRAM_WORDS)
    ) u_sram (
        .CLK   (CLK),
        .nRST  (nRST),
        .stb   (sram_stb),
        .we    (wb_we),
        .adr   (wb_adr),
        .sel   (wb_sel),
        .wdata (wb_wdata),
        .rdata (sram_rdata),
        .ack   (sram_ack)
    );

    wb_periph #(
        .PERIPH_WAIT (PERIPH_WAIT)
    ) u_periph (
        .CLK   (CLK),
        .nRST  (nRST),
        .stb   (periph_stb),
        .we    (wb_we),
        .adr   (wb_adr),
        .sel   (wb_sel),
        .wdata (wb_wdata),
        .rdata (periph_rdata),
        .ack   (periph_ack)
    );

endmodule

// File: tb/wb_soc_assert.sv
/*
  Concurrent checks on the Wishbone outputs of the manager, bound into
  every wb_manager instance. The testbench reads fail_cnt at the end.
*/
`timescale 1ns/1ps

module wb_soc_assert (
    input logic                          CLK,
    input logic                          nRST,
    input logic [wb_pkg::WB_ADR_W-1:0]   wb_adr,
    input logic [wb_pkg::WB_SEL_W-1:0]   wb_sel,
    input logic                          wb_we,
    input logic                          wb_stb,
    input logic                          wb_cyc,
    input logic                          wb_ack,
    input logic                          busy,
    input wb_pkg::mgr_state_t            state
);
    import wb_pkg::*;

    int fail_cnt = 0;

    stb_eq_cyc: assert property (@(posedge CLK) disable iff (!nRST) wb_stb == wb_cyc)
        else begin
            fail_cnt++;
            $error("stb and cyc differ");
        end

    we_needs_stb: assert property (@(posedge CLK) disable iff (!nRST) !wb_stb |-> !wb_we)
        else begin
            fail_cnt++;
            $error("we high outside a bus cycle");
        end

    // request held until the subordinate acks
    req_stable: assert property (@(posedge CLK) disable iff (!nRST)
        wb_stb && !wb_ack |=> $stable(wb_adr) && $stable(wb_sel))
        else begin
            fail_cnt++;
            $error("adr or sel changed before ack");
        end

    busy_in_cycle: assert property (@(posedge CLK) disable iff (!nRST)
        wb_stb |-> busy && (state == WRITE || state == READ))
        else begin
            fail_cnt++;
            $error("stb high while busy low or manager idle");
        end

endmodule

bind wb_manager wb_soc_assert u_assert (
    .CLK    (CLK),
    .nRST   (nRST),
    .wb_adr (wb_adr),
    .wb_sel (wb_sel),
    .wb_we  (wb_we),
    .wb_stb (wb_stb),
    .wb_cyc (wb_cyc),
    .wb_ack (wb_ack),
    .busy   (busy),
    .state  (state)
);

// File: tb/wb_soc_tb.sv
/*
  Testbench for the Wishbone system. Issues single transfers on the user
  port, predicts read data with a shadow model of the SRAM and of the
  peripheral registers, and checks read data, busy length and the poison
  word after every transfer. Bus-side rules are checked by bound assertions.
*/
`timescale 1ns/1ps

module wb_soc_tb;
    import wb_pkg::*;

    localparam int SRAM_WORDS   = 256;
    localparam int PERIPH_WAIT  = 2;
    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_RAND     = 64;
    // fill, random writes and reads, directed transfers with some margin
    localparam int NUM_TRANS    = SRAM_WORDS + 2 * NUM_RAND + 16;

    logic                CLK;
    logic                nRST;
    logic                write;
    logic                read;
    logic [WB_ADR_W-1:0] adr;
    logic [WB_SEL_W-1:0] sel;
    logic [WB_DAT_W-1:0] wdata;
    logic [WB_DAT_W-1:0] rdata;
    logic                busy;

    logic [31:0]         lfsr;
    logic [WB_DAT_W-1:0] shadow_mem [SRAM_WORDS];
    logic [WB_DAT_W-1:0] shadow_scratch;
    logic [WB_ADR_W-1:0] rand_adr [NUM_RAND];
    logic [WB_DAT_W-1:0] count0;
    logic [WB_DAT_W-1:0] last_rdata;

    // one entry per transfer in issue order
    logic [WB_DAT_W-1:0] exp_q [$];
    bit                  chk_q [$];
    int                  len_q [$];
    int                  issued;
    int                  done_cnt;

    wb_soc #(
        .SRAM_WORDS  (SRAM_WORDS),
        .PERIPH_WAIT (PERIPH_WAIT)
    ) uut (
        .CLK   (CLK),
        .nRST  (nRST),
        .write (write),
        .read  (read),
        .adr   (adr),
        .sel   (sel),
        .wdata (wdata),
        .rdata (rdata),
        .busy  (busy)
    );

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [WB_DAT_W-1:0] merge_bytes(input logic [WB_DAT_W-1:0] old,
                                                        input logic [WB_SEL_W-1:0] s,
                                                        input logic [WB_DAT_W-1:0] d);
        logic [WB_DAT_W-1:0] m;
        m = old;
        for (int i = 0; i < WB_SEL_W; i++) begin
            if (s[i]) begin
                m[i*8 +: 8] = d[i*8 +: 8];
            end
        end
        return m;
    endfunction

    // applies a write to the shadow state and returns what a read would see
    function automatic logic [WB_DAT_W-1:0] ref_access(input bit is_write,
                                                       input logic [WB_ADR_W-1:0] a,
                                                       input logic [WB_SEL_W-1:0] s,
                                                       input logic [WB_DAT_W-1:0] d);
        int idx;
        idx = int'((a >> 2) % SRAM_WORDS);
        if (a[31:16] == 16'h0000) begin
            if (is_write) begin
                shadow_mem[idx] = merge_bytes(shadow_mem[idx], s, d);
            end
            return shadow_mem[idx];
        end
        if (a[31:16] == 16'h0001) begin
            if (a[15:0] == 16'h0004) begin
                if (is_write) begin
                    shadow_scratch = merge_bytes(shadow_scratch, s, d);
                end
                return shadow_scratch;
            end
            // counter at offset 0 is checked by ordering only
            return (a[15:0] == 16'h0008) ? PERIPH_ID_WORD : '0;
        end
        return UNMAPPED_WORD;
    endfunction

    function automatic int expected_busy(input logic [WB_ADR_W-1:0] a);
        return (a[31:16] == 16'h0001) ? 3 + PERIPH_WAIT : 4;
    endfunction

    task automatic report_error(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic transfer(input bit is_write, input logic [WB_ADR_W-1:0] a,
                            input logic [WB_SEL_W-1:0] s, input logic [WB_DAT_W-1:0] d,
                            input bit chk);
        exp_q.push_back(ref_access(is_write, a, s, d));
        chk_q.push_back(chk && !is_write);
        len_q.push_back(expected_busy(a));
        issued++;
        @(posedge CLK);
        write <= is_write;
        read  <= !is_write;
        adr   <= a;
        sel   <= s;
        wdata <= d;
        do begin
            @(negedge CLK);
        end while (!busy);
        // drop the request once it has been taken
        @(posedge CLK);
        write <= 1'b0;
        read  <= 1'b0;
        wait (done_cnt == issued);
    endtask

    initial begin : compare
        int                  len;
        int                  want;
        bit                  chk;
        logic [WB_DAT_W-1:0] exp;
        forever begin
            @(negedge CLK);
            if (busy) begin
                len = 0;
                while (busy) begin
                    len++;
                    @(negedge CLK);
                end
                exp  = exp_q.pop_front();
                chk  = chk_q.pop_front();
                want = len_q.pop_front();
                assert (len == want)
                    else report_error($sformatf("busy high %0d cycles at %h, expected %0d",
                                                len, adr, want));
                if (chk) begin
                    assert (rdata === exp)
                        else report_error($sformatf("read at %h got %h, expected %h",
                                                    adr, rdata, exp));
                end
                last_rdata = rdata;
                @(negedge CLK);
                if (chk) begin
                    // read word stays for a second idle cycle
                    assert (rdata === exp)
                        else report_error($sformatf("read at %h not held, got %h, expected %h",
                                                    adr, rdata, exp));
                end
                @(negedge CLK);
                assert (rdata === MGR_POISON_WORD)
                    else report_error($sformatf("rdata %h two cycles after busy fell", rdata));
                done_cnt++;
            end
        end
    end

    initial begin : watchdog
        #(CLK_PERIOD * (RESET_CYCLES + NUM_TRANS * 20));
        $display("Timeout: the transfers did not finish in the expected time");
        $display("Errors found");
        $fatal(1);
    end

    initial begin : stimulus
        logic [WB_ADR_W-1:0] a;
        CLK            = 1'b0;
        nRST           = 1'b0;
        write          = 1'b0;
        read           = 1'b0;
        adr            = '0;
        sel            = '0;
        wdata          = '0;
        lfsr           = 32'h4ae9_60e5;
        issued         = 0;
        done_cnt       = 0;
        shadow_scratch = '0;
        repeat (RESET_CYCLES) @(posedge CLK);
        nRST <= 1'b1;

        repeat (4) begin
            @(negedge CLK);
            assert (busy === 1'b0 && rdata === '0)
                else report_error("busy or rdata not cleared after reset");
        end

        // known contents in every SRAM word
        for (int i = 0; i < SRAM_WORDS; i++) begin
            a = WB_ADR_W'(i * 4);
            transfer(1'b1, a, 4'hF, (a * 32'h9E37_79B9) ^ 32'h0F1E_2D3C, 1'b0);
        end
        for (int i = 0; i < NUM_RAND; i++) begin
            rand_adr[i] = rand_bits(14) << 2;
            transfer(1'b1, rand_adr[i], WB_SEL_W'(rand_bits(4)), rand_bits(32), 1'b0);
        end
        for (int i = 0; i < NUM_RAND; i++) begin
            transfer(1'b0, rand_adr[i], 4'hF, '0, 1'b1);
        end

        // peripheral registers
        transfer(1'b1, PERIPH_BASE + 32'h4, 4'hF, rand_bits(32), 1'b0);
        transfer(1'b1, PERIPH_BASE + 32'h4, 4'b0101, rand_bits(32), 1'b0);
        transfer(1'b0, PERIPH_BASE + 32'h4, 4'hF, '0, 1'b1);
        transfer(1'b0, PERIPH_BASE + 32'h8, 4'hF, '0, 1'b1);
        transfer(1'b0, PERIPH_BASE + 32'hC, 4'hF, '0, 1'b1);
        transfer(1'b0, PERIPH_BASE, 4'hF, '0, 1'b0);
        count0 = last_rdata;
        transfer(1'b0, PERIPH_BASE, 4'hF, '0, 1'b0);
        assert (last_rdata > count0)
            else report_error($sformatf("counter read %h after %h", last_rdata, count0));

        // writes to the unmapped region must not reach either subordinate
        transfer(1'b0, 32'h0005_0000, 4'hF, '0, 1'b1);
        transfer(1'b1, 32'h0005_0000, 4'hF, rand_bits(32), 1'b0);
        transfer(1'b1, 32'h0005_0004, 4'hF, rand_bits(32), 1'b0);
        transfer(1'b0, 32'h0000_0000, 4'hF, '0, 1'b1);
        transfer(1'b0, PERIPH_BASE + 32'h4, 4'hF, '0, 1'b1);

        // both request levels together are ignored
        @(posedge CLK);
        write <= 1'b1;
        read  <= 1'b1;
        adr   <= 32'h0000_0010;
        repeat (6) begin
            @(negedge CLK);
            assert (busy === 1'b0)
                else report_error("request taken with write and read both high");
        end
        @(posedge CLK);
        write <= 1'b0;
        read  <= 1'b0;
        transfer(1'b0, 32'h0000_0010, 4'hF, '0, 1'b1);

        repeat (2) @(posedge CLK);
        if (uut.u_manager.u_assert.fail_cnt == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Errors found");
            $fatal(1);
        end
    end

endmodule

// File: wb_soc.f
logic/wb_pkg.sv
logic/wb_manager.sv
logic/wb_decoder.sv
logic/wb_sram.sv
logic/wb_periph.sv
logic/wb_soc.sv
tb/wb_soc_assert.sv
tb/wb_soc_tb.sv
